//--- build.f
rv_pkg.sv
main_decoder.sv
alu_decoder.sv
control_unit.sv
alu.sv
imm_gen.sv
reg_file.sv
lsu.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv

//--- tb_rv_core.sv
module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 3;
    localparam int    DRIVE_DELAY  = 2;           // After the rising edge
    localparam int    SEED         = 62;
    localparam int    IMEM_WORDS   = 256;
    localparam int    DMEM_BYTES   = 1024;
    localparam int    ALU_OPS      = 48;          // Random R/I/U instructions
    localparam word_t NOP          = 32'h0000_0013;

    logic      clk = 1'b0;
    logic      arst_n = 1'b0;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;

    word_t      imem [IMEM_WORDS];
    logic [7:0] dmem [DMEM_BYTES];                // Seen by the DUT
    logic [7:0] ref_mem [DMEM_BYTES];             // ISS copy
    word_t      rf [32];                          // ISS registers
    word_t      ref_pc = '0;
    word_t      end_pc = '0;
    int         prog_len = 0;

    rv_core dut_i (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign imem_data  = imem[imem_addr[9:2]];     // Same-cycle fetch
    assign dmem_rdata = {dmem[dmem_req.addr[9:0] + 10'd3], dmem[dmem_req.addr[9:0] + 10'd2],
                         dmem[dmem_req.addr[9:0] + 10'd1], dmem[dmem_req.addr[9:0]]};

    always @(posedge clk) begin
        if (dmem_req.we) begin
            for (int k = 0; k < 4; k++) begin
                if (dmem_req.be[k]) dmem[10'(dmem_req.addr + k)] <= dmem_req.wdata[8*k +: 8];
            end
        end
    end

    function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t u_type(logic [19:0] imm, reg_addr_t rd, opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic word_t j_type(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [7:0] fill_byte(logic [9:0] a);
        return a[7:0] ^ {4{a[9:8]}} ^ 8'h5A;      // Every address bit counts
    endfunction

    function automatic word_t alu_ref(logic [2:0] f3, word_t a, word_t b, logic alt);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return word_t'($signed(a) < $signed(b));
            3'b011:  return word_t'(a < b);
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // One instruction of the ISS, returns the store it should issue
    function automatic dmem_req_t ref_step(input word_t ins, output word_t npc);
        dmem_req_t  req;
        word_t      a, b, addr, ld, res;
        word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
        logic [2:0] f3;
        logic       wr;
        logic       take;
        a     = rf[ins[19:15]];
        b     = rf[ins[24:20]];
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        req   = '0;
        res   = '0;
        wr    = 1'b1;
        npc   = ref_pc + 4;
        case (ins[6:0])
            OP_REG:   res = alu_ref(f3, a, b, ins[30]);
            OP_IMM:   res = alu_ref(f3, a, imm_i, ins[30] && f3 == 3'b101); // Only srai
            OP_LUI:   res = imm_u;
            OP_AUIPC: res = ref_pc + imm_u;
            OP_JAL: begin
                res = ref_pc + 4;
                npc = ref_pc + imm_j;
            end
            OP_JALR: begin
                res = ref_pc + 4;
                npc = (a + imm_i) & ~32'd1;
            end
            OP_BRANCH: begin
                wr = 1'b0;
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    default: take = (a >= b);
                endcase
                if (take) npc = ref_pc + imm_b;
            end
            OP_LOAD: begin
                addr = a + imm_i;
                ld   = {ref_mem[10'(addr + 3)], ref_mem[10'(addr + 2)],
                        ref_mem[10'(addr + 1)], ref_mem[10'(addr)]};
                case (f3)
                    3'b000:  res = {{24{ld[7]}}, ld[7:0]};
                    3'b001:  res = {{16{ld[15]}}, ld[15:0]};
                    3'b100:  res = {24'b0, ld[7:0]};
                    3'b101:  res = {16'b0, ld[15:0]};
                    default: res = ld;
                endcase
            end
            OP_STORE: begin
                wr        = 1'b0;
                addr      = a + imm_s;
                req.addr  = {addr[31:2], 2'b00};
                req.be    = be_t'(((1 << (1 << f3[1:0])) - 1) << addr[1:0]); // 1, 2 or 4 lanes
                req.wdata = b << (8 * addr[1:0]);
                req.we    = 1'b1;
                for (int k = 0; k < (1 << f3[1:0]); k++) begin
                    ref_mem[10'(addr + k)] = b[8*k +: 8];
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) rf[ins[11:7]] = res;
        return req;
    endfunction

    task automatic emit(input word_t ins);
        imem[prog_len] = ins;
        prog_len++;
    endtask

    task automatic build_program();
        word_t       r;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        reg_addr_t   ld_rd;
        ld_rd = 5'd7;                             // Load targets x7 and up, never reused
        for (int a = 0; a < IMEM_WORDS; a++) imem[a] = NOP;
        for (int a = 0; a < DMEM_BYTES; a++) begin
            dmem[a]    = fill_byte(10'(a));
            ref_mem[a] = fill_byte(10'(a));
        end
        for (int i = 0; i < 32; i++) rf[i] = '0;
        for (int i = 1; i < 32; i++) begin        // Random start value per register
            r = $urandom;
            emit(u_type(r[31:12], reg_addr_t'(i), OP_LUI));
            emit(i_type(r[11:0], reg_addr_t'(i), 3'b000, reg_addr_t'(i), OP_IMM));
        end
        emit(i_type(12'h7FF, 5'd1, 3'b000, 5'd0, OP_IMM)); // Write to x0 is dropped
        for (int n = 0; n < ALU_OPS; n++) begin
            r   = $urandom;
            f3  = r[2:0];
            alt = r[3] && (f3 == 3'b000 || f3 == 3'b101);
            imm = (f3[1:0] == 2'b01) ? {1'b0, alt, 5'b0, r[24:20]} : r[31:20]; // Shamt form
            case (r[5:4])
                2'b10:   emit(i_type(imm, r[14:10], f3, r[19:15], OP_IMM));
                2'b11:   emit(u_type(r[31:12], r[19:15], r[6] ? OP_AUIPC : OP_LUI));
                default: emit(r_type({1'b0, alt, 5'b0}, r[24:20], r[14:10], f3, r[19:15]));
            endcase
        end
        for (int off = 0; off < 4; off++) begin   // sb, lb, lbu on every lane
            r = $urandom;
            emit(s_type(12'(12'h100 + off), r[4:0], 5'd0, 3'b000));
            emit(i_type(12'(12'h100 + off), 5'd0, 3'b000, ld_rd++, OP_LOAD));
            emit(i_type(12'(12'h100 + off), 5'd0, 3'b100, ld_rd++, OP_LOAD));
            emit(i_type(12'(12'h180 + off), 5'd0, 3'b000, ld_rd++, OP_LOAD)); // Fill data
        end
        for (int off = 0; off < 4; off += 2) begin
            r = $urandom;
            emit(s_type(12'(12'h110 + off), r[4:0], 5'd0, 3'b001));
            emit(i_type(12'(12'h110 + off), 5'd0, 3'b001, ld_rd++, OP_LOAD));
            emit(i_type(12'(12'h190 + off), 5'd0, 3'b101, ld_rd++, OP_LOAD));
        end
        emit(s_type(12'h120, 5'd3, 5'd0, 3'b010));
        emit(i_type(12'h120, 5'd0, 3'b010, ld_rd++, OP_LOAD));
        emit(i_type(12'h1A0, 5'd0, 3'b010, ld_rd++, OP_LOAD));
        emit(i_type(12'hFFB, 5'd0, 3'b000, 5'd30, OP_IMM)); // x30 = -5
        emit(i_type(12'd3, 5'd0, 3'b000, 5'd31, OP_IMM));
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin           // Signed and unsigned disagree on -5 vs 3
                for (int p = 0; p < 3; p++) begin
                    emit(b_type(13'd8, (p == 0) ? 5'd31 : 5'd30, (p == 1) ? 5'd31 : 5'd30,
                                3'(f)));
                    emit(i_type(12'd1, 5'd29, 3'b000, 5'd29, OP_IMM)); // Skipped when taken
                end
            end
        end
        emit(j_type(21'd8, 5'd1));
        emit(i_type(12'd1, 5'd29, 3'b000, 5'd29, OP_IMM));
        emit(u_type(20'd0, 5'd5, OP_AUIPC));
        emit(i_type(12'd13, 5'd5, 3'b000, 5'd6, OP_JALR)); // Odd target, bit 0 cleared
        emit(i_type(12'd1, 5'd29, 3'b000, 5'd29, OP_IMM));
        for (int i = 0; i < 32; i++) begin        // Register dump
            emit(s_type(12'(12'h200 + 4 * i), reg_addr_t'(i), 5'd0, 3'b010));
        end
        end_pc = word_t'(prog_len * 4);
        emit(j_type(21'd0, 5'd0));                // Spin here
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_pc(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s: expected %08h, actual %08h", name, exp, act));
        end
    endtask

    task automatic check_store(input string name, input dmem_req_t exp, input dmem_req_t act);
        if (exp.we ? (act !== exp) : (act.we !== 1'b0)) begin
            abort_run($sformatf({"[FAIL] %s: expected addr %08h wdata %08h be %h we %b,",
                                 " actual addr %08h wdata %08h be %h we %b"}, name,
                                exp.addr, exp.wdata, exp.be, exp.we,
                                act.addr, act.wdata, act.be, act.we));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
    end

    initial begin : compare_proc
        dmem_req_t exp_req;
        word_t     npc;
        @(negedge clk);
        check_pc("pc in reset", '0, imem_addr);
        @(posedge arst_n);
        while (ref_pc != end_pc) begin
            @(negedge clk);
            check_pc($sformatf("fetch at %08h", ref_pc), ref_pc, imem_addr);
            exp_req = ref_step(imem[ref_pc[9:2]], npc);
            check_store($sformatf("dmem request at %08h", ref_pc), exp_req, dmem_req);
            ref_pc = npc;
        end
        @(negedge clk);
        check_pc("end of program", end_pc, imem_addr);
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin : assertion_monitor
        wait (dut_i.props_i.fail_count != 0);     // First failed assertion in the core
        abort_run("An assertion inside the core failed, see the error above");
    end

    initial begin : watchdog
        wait (prog_len != 0);
        #(prog_len * CLK_PERIOD * 2);
        abort_run("Watchdog expired before the program reached its end");
    end

endmodule

//--- rv_core_props.sv
module rv_core_props (
    input logic              clk_i,
    input logic              arst_n_i,
    input rv_pkg::word_t     pc_i,                // Fetch address of the core
    input rv_pkg::dmem_req_t dmem_req_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;                           // Failed assertions so far

    a_no_store_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !dmem_req_i.we)
        else begin
            $error("store strobe high while reset is held");
            fail_count++;
        end

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i) pc_i[1:0] == 2'b00)
        else begin
            $error("PC is not word-aligned");
            fail_count++;
        end

    // Any store must enable at least one lane
    a_be_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                   dmem_req_i.we |-> dmem_req_i.be != '0)
        else begin
            $error("store issued with no byte enabled");
            fail_count++;
        end

endmodule

bind rv_core rv_core_props props_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .pc_i       (imem_addr_o),
    .dmem_req_i (dmem_req_o)
);

//--- rv_core.sv
module rv_core (
    input  logic              clk_i,
    input  logic              arst_n_i,
    output rv_pkg::word_t     imem_addr_o,        // Fetch address
    input  rv_pkg::word_t     imem_data_i,        // Instruction, same cycle
    output rv_pkg::dmem_req_t dmem_req_o,
    input  rv_pkg::word_t     dmem_rdata_i        // Word at request address
);
    import rv_pkg::*;

    word_t     pc_q;
    word_t     pc_next;
    word_t     pc_plus4;
    word_t     pc_target;                         // PC + imm
    word_t     imm;
    word_t     rd1;
    word_t     rd2;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    word_t     load_data;
    word_t     wb_data;
    ctrl_t     ctrl;
    logic      pc_src;
    logic      zero;
    dmem_req_t lsu_req;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign imem_addr_o = pc_q;
    assign pc_plus4    = pc_q + 32'd4;
    assign pc_target   = pc_q + imm;

    // jalr target has bit 0 cleared
    assign pc_next = !pc_src      ? pc_plus4 :
                     ctrl.is_jalr ? {alu_result[XLEN-1:1], 1'b0} : pc_target;

    control_unit ctrl_i (
        .opcode_i     (imem_data_i[6:0]),
        .funct3_i     (imem_data_i[14:12]),
        .funct7_i     (imem_data_i[31:25]),
        .zero_i       (zero),
        .alu_result_i (alu_result),
        .ctrl_o       (ctrl),
        .pc_src_o     (pc_src)
    );

    imm_gen imm_i (.instr_i(imem_data_i), .imm_src_i(ctrl.imm_src), .imm_o(imm));

    reg_file rf_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .rs1_i    (imem_data_i[19:15]),
        .rs2_i    (imem_data_i[24:20]),
        .rd_i     (imem_data_i[11:7]),
        .wr_en_i  (ctrl.reg_wr_en),
        .wd_i     (wb_data),
        .rd1_o    (rd1),
        .rd2_o    (rd2)
    );

    assign alu_a = ctrl.alu_src_a_sel ? pc_q : rd1; // PC for auipc
    assign alu_b = ctrl.alu_src ? imm : rd2;

    alu alu_i (.a_i(alu_a), .b_i(alu_b), .ctrl_i(ctrl.alu_ctrl),
               .result_o(alu_result), .zero_o(zero));

    lsu lsu_i (
        .addr_i        (alu_result),
        .store_data_i  (rd2),
        .rdata_i       (dmem_rdata_i),
        .byte_en_i     (ctrl.byte_en),
        .load_signed_i (ctrl.load_signed),
        .mem_wr_en_i   (ctrl.mem_wr_en),
        .req_o         (lsu_req),
        .load_data_o   (load_data)
    );

    always_comb begin
        dmem_req_o    = lsu_req;
        dmem_req_o.we = lsu_req.we & arst_n_i;    // No store while in reset
    end

    always_comb begin
        case (ctrl.result_src)
            RES_MEM: wb_data = load_data;
            RES_PC4: wb_data = pc_plus4;          // Link address
            default: wb_data = alu_result;
        endcase
    end

endmodule

//--- lsu.sv
module lsu (
    input  rv_pkg::word_t     addr_i,             // Byte address from ALU
    input  rv_pkg::word_t     store_data_i,       // rs2
    input  rv_pkg::word_t     rdata_i,            // Word from data memory
    input  rv_pkg::be_t       byte_en_i,          // 1, 3 or F
    input  logic              load_signed_i,
    input  logic              mem_wr_en_i,
    output rv_pkg::dmem_req_t req_o,
    output rv_pkg::word_t     load_data_o
);
    import rv_pkg::*;

    logic [4:0] lane_shift;                       // Byte offset in bits
    word_t      rdata_shifted;
    logic       byte_msb;
    logic       half_msb;

    assign lane_shift = {addr_i[1:0], 3'b000};

    assign req_o.addr  = {addr_i[XLEN-1:2], 2'b00};
    assign req_o.wdata = store_data_i << lane_shift;
    assign req_o.be    = byte_en_i << addr_i[1:0];
    assign req_o.we    = mem_wr_en_i;

    assign rdata_shifted = rdata_i >> lane_shift; // Addressed lane to bit 0
    assign byte_msb      = load_signed_i & rdata_shifted[7];
    assign half_msb      = load_signed_i & rdata_shifted[15];

    always_comb begin
        case (byte_en_i)
            4'h1:    load_data_o = {{24{byte_msb}}, rdata_shifted[7:0]};
            4'h3:    load_data_o = {{16{half_msb}}, rdata_shifted[15:0]};
            default: load_data_o = rdata_shifted; // lw, offset is zero
        endcase
    end

endmodule

//--- reg_file.sv
module reg_file (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  rv_pkg::reg_addr_t   rs1_i,
    input  rv_pkg::reg_addr_t   rs2_i,
    input  rv_pkg::reg_addr_t   rd_i,
    input  logic                wr_en_i,
    input  rv_pkg::word_t       wd_i,
    output rv_pkg::word_t       rd1_o,
    output rv_pkg::word_t       rd2_o
);
    import rv_pkg::*;

    word_t regs [1:31];                           // x0 has no storage

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs <= '{default: '0};
        end else if (wr_en_i && rd_i != '0) begin // Drop writes to x0
            regs[rd_i] <= wd_i;
        end
    end

    assign rd1_o = (rs1_i == '0) ? '0 : regs[rs1_i]; // Combinational reads
    assign rd2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- imm_gen.sv
module imm_gen (
    input  rv_pkg::word_t    instr_i,
    input  rv_pkg::imm_src_e imm_src_i,
    output rv_pkg::word_t    imm_o
);
    import rv_pkg::*;

    logic sign;

    assign sign = instr_i[31];                    // Immediate sign is always bit 31

    always_comb begin
        case (imm_src_i)
            IMM_I:   imm_o = {{20{sign}}, instr_i[31:20]};
            IMM_S:   imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            IMM_B:   imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                              instr_i[11:8], 1'b0};
            IMM_U:   imm_o = {instr_i[31:12], 12'b0};
            IMM_J:   imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                              instr_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

//--- alu.sv
module alu (
    input  rv_pkg::word_t     a_i,
    input  rv_pkg::word_t     b_i,
    input  rv_pkg::alu_ctrl_e ctrl_i,
    output rv_pkg::word_t     result_o,
    output logic              zero_o              // Result is all zeros
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];                      // Only low 5 bits shift

    always_comb begin
        case (ctrl_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            SLL:     result_o = a_i << shamt;
            SLT:     result_o = word_t'($signed(a_i) < $signed(b_i));
            SLTU:    result_o = word_t'(a_i < b_i);
            XOR:     result_o = a_i ^ b_i;
            SRL:     result_o = a_i >> shamt;
            SRA:     result_o = word_t'($signed(a_i) >>> shamt);
            OR:      result_o = a_i | b_i;
            AND:     result_o = a_i & b_i;
            PASS_B:  result_o = b_i;              // lui
            default: result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

//--- control_unit.sv
module control_unit (
    input  rv_pkg::opcode_t opcode_i,
    input  logic [2:0]      funct3_i,
    input  logic [6:0]      funct7_i,
    input  logic            zero_i,               // ALU zero flag
    input  rv_pkg::word_t   alu_result_i,         // Compare result for branches
    output rv_pkg::ctrl_t   ctrl_o,               // Complete controls
    output logic            pc_src_o              // Take branch or jump target
);
    import rv_pkg::*;

    ctrl_t      dec_ctrl;                         // Main decoder output
    alu_op_e    alu_op;
    alu_ctrl_e  alu_ctrl;
    logic       branch;
    logic       less;                             // SLT/SLTU said less-than
    logic       branch_cond;
    logic [6:0] funct7_alu;

    // Immediate bits in funct7 only mean SRAI; elsewhere they are just imm
    assign funct7_alu = (opcode_i == OP_IMM && funct3_i != F3_SR) ? 7'b0 : funct7_i;

    main_decoder main_dec (
        .opcode_i (opcode_i),
        .funct3_i (funct3_i),
        .funct7_i (funct7_i),
        .ctrl_o   (dec_ctrl),
        .branch_o (branch),
        .alu_op_o (alu_op)
    );

    alu_decoder alu_dec (
        .alu_op_i   (alu_op),
        .funct3_i   (funct3_i),
        .funct7_i   (funct7_alu),
        .alu_ctrl_o (alu_ctrl)
    );

    always_comb begin
        ctrl_o          = dec_ctrl;
        ctrl_o.alu_ctrl = alu_ctrl;               // Merge exact operation
    end

    assign less = |alu_result_i;

    always_comb begin
        case (funct3_i)
            F3_BEQ:  branch_cond = zero_i;
            F3_BNE:  branch_cond = ~zero_i;
            F3_BLT:  branch_cond = less;
            F3_BGE:  branch_cond = ~less;
            F3_BLTU: branch_cond = less;          // From SLTU, not a subtraction
            F3_BGEU: branch_cond = ~less;
            default: branch_cond = 1'b0;          // Reserved encodings
        endcase
    end

    always_comb begin
        case (opcode_i)
            OP_JAL, OP_JALR: pc_src_o = branch;   // Always taken
            default:         pc_src_o = branch & branch_cond;
        endcase
    end

endmodule

//--- alu_decoder.sv
module alu_decoder (
    input  rv_pkg::alu_op_e   alu_op_i,           // Class from main decoder
    input  logic [2:0]        funct3_i,
    input  logic [6:0]        funct7_i,           // Zeroed upstream for non-shift immediates
    output rv_pkg::alu_ctrl_e alu_ctrl_o
);
    import rv_pkg::*;

    logic alt;                                    // SUB / SRA select

    assign alt = funct7_i[5];

    always_comb begin
        case (alu_op_i)
            ALUOP_ADD: alu_ctrl_o = ADD;          // Address generation
            ALUOP_LUI: alu_ctrl_o = PASS_B;
            ALUOP_BRANCH: begin
                case (funct3_i)
                    F3_BEQ, F3_BNE: alu_ctrl_o = SUB;  // Zero flag on equal
                    F3_BLT, F3_BGE: alu_ctrl_o = SLT;
                    default:        alu_ctrl_o = SLTU; // bltu, bgeu
                endcase
            end
            default: begin                        // ALUOP_FUNCT
                case (funct3_i)
                    F3_ADD:  alu_ctrl_o = alt ? SUB : ADD;
                    F3_SLL:  alu_ctrl_o = SLL;
                    F3_SLT:  alu_ctrl_o = SLT;
                    F3_SLTU: alu_ctrl_o = SLTU;
                    F3_XOR:  alu_ctrl_o = XOR;
                    F3_SR:   alu_ctrl_o = alt ? SRA : SRL;
                    F3_OR:   alu_ctrl_o = OR;
                    default: alu_ctrl_o = AND;    // F3_AND
                endcase
            end
        endcase
    end

endmodule

//--- main_decoder.sv
module main_decoder (
    input  rv_pkg::opcode_t opcode_i,             // Instruction [6:0]
    input  logic [2:0]      funct3_i,             // Instruction [14:12]
    input  logic [6:0]      funct7_i,             // Instruction [31:25]
    output rv_pkg::ctrl_t   ctrl_o,               // Datapath controls, alu_ctrl at ADD
    output logic            branch_o,             // Branch or jump
    output rv_pkg::alu_op_e alu_op_o              // ALU-op class
);
    import rv_pkg::*;

    be_t size_be;                                 // Access size as enable pattern

    always_comb begin
        case (funct3_i[1:0])
            2'b00:   size_be = 4'h1;              // Byte
            2'b01:   size_be = 4'h3;              // Halfword
            default: size_be = 4'hF;              // Word
        endcase
    end

    always_comb begin
        ctrl_o            = '0;
        ctrl_o.imm_src    = IMM_I;
        ctrl_o.result_src = RES_ALU;
        ctrl_o.alu_ctrl   = ADD;                  // Filled in by control_unit
        ctrl_o.byte_en    = 4'hF;
        branch_o          = 1'b0;
        alu_op_o          = ALUOP_ADD;
        case (opcode_i)
            OP_REG: begin
                ctrl_o.reg_wr_en = (funct7_i != F7_MULDIV); // No write for mul/div
                alu_op_o         = ALUOP_FUNCT;
            end
            OP_IMM: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                alu_op_o         = ALUOP_FUNCT;
            end
            OP_LOAD: begin
                ctrl_o.reg_wr_en   = 1'b1;
                ctrl_o.alu_src     = 1'b1;        // rs1 + offset
                ctrl_o.result_src  = RES_MEM;
                ctrl_o.byte_en     = size_be;
                ctrl_o.load_signed = ~funct3_i[2]; // lbu/lhu have bit 2 set
            end
            OP_STORE: begin
                ctrl_o.mem_wr_en = 1'b1;
                ctrl_o.imm_src   = IMM_S;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.byte_en   = size_be;
            end
            OP_BRANCH: begin
                ctrl_o.imm_src = IMM_B;           // Target is PC + imm
                branch_o       = 1'b1;
                alu_op_o       = ALUOP_BRANCH;    // rs1 against rs2
            end
            OP_JAL: begin
                ctrl_o.reg_wr_en  = 1'b1;
                ctrl_o.imm_src    = IMM_J;
                ctrl_o.result_src = RES_PC4;      // Link address
                branch_o          = 1'b1;
            end
            OP_JALR: begin
                ctrl_o.reg_wr_en  = 1'b1;
                ctrl_o.alu_src    = 1'b1;         // Target rs1 + imm
                ctrl_o.result_src = RES_PC4;
                ctrl_o.is_jalr    = 1'b1;
                branch_o          = 1'b1;
            end
            OP_LUI: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.imm_src   = IMM_U;
                ctrl_o.alu_src   = 1'b1;
                alu_op_o         = ALUOP_LUI;
            end
            OP_AUIPC: begin
                ctrl_o.reg_wr_en     = 1'b1;
                ctrl_o.imm_src       = IMM_U;
                ctrl_o.alu_src       = 1'b1;
                ctrl_o.alu_src_a_sel = 1'b1;      // PC + upper imm
            end
            default: ;                            // Unknown opcode is a nop
        endcase
    end

endmodule

//--- rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;                     // Data and address width

    typedef logic [XLEN-1:0] word_t;              // Data, address, PC
    typedef logic [4:0]      reg_addr_t;          // Register index
    typedef logic [6:0]      opcode_t;            // Major opcode
    typedef logic [3:0]      be_t;                // Byte enables, one per lane

    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ALU funct3, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;    // SRL or SRA by funct7[5]
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_MULDIV = 7'b0000001; // M extension, not supported

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_src_e;

    // Fourth code carries lui through to PASS_B
    typedef enum logic [1:0] {ALUOP_ADD, ALUOP_BRANCH, ALUOP_FUNCT, ALUOP_LUI} alu_op_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_ctrl_e;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} result_src_e;

    typedef struct packed {
        logic        reg_wr_en;                   // Write rd
        logic        mem_wr_en;                   // Store
        imm_src_e    imm_src;                     // Immediate format
        logic        alu_src;                     // B operand is immediate
        logic        alu_src_a_sel;               // A operand is PC
        result_src_e result_src;                  // Writeback source
        alu_ctrl_e   alu_ctrl;                    // ALU operation
        be_t         byte_en;                     // Word-relative access size
        logic        load_signed;                 // Sign-extend loads
        logic        is_jalr;                     // Target from ALU
    } ctrl_t;

    typedef struct packed {
        word_t addr;                              // Word-aligned address
        word_t wdata;                             // Lane-aligned store data
        be_t   be;                                // Lane enables
        logic  we;                                // Store strobe
    } dmem_req_t;

endpackage
